// ==== common/rvc_pkg.sv ====
//////////////////////////////
// shared types for the RV32C expansion stage
// base RV32C only, no Zc and no float expansion
// every compressed view is exactly 16 bits wide
//////////////////////////////

package rvc_pkg;

  // word widths are fixed by the ISA
  localparam int unsigned ilen_p = 32;
  localparam int unsigned clen_p = 16;

  //////////////////////////////
  // RV32I major opcodes
  localparam logic [6:0] opcode_load   = 7'b0000011;
  localparam logic [6:0] opcode_store  = 7'b0100011;
  localparam logic [6:0] opcode_opimm  = 7'b0010011;
  localparam logic [6:0] opcode_op     = 7'b0110011;
  localparam logic [6:0] opcode_lui    = 7'b0110111;
  localparam logic [6:0] opcode_jal    = 7'b1101111;
  localparam logic [6:0] opcode_jalr   = 7'b1100111;
  localparam logic [6:0] opcode_branch = 7'b1100011;

  // fixed register numbers
  localparam logic [4:0] reg_zero_c = 5'd0;
  localparam logic [4:0] reg_ra_c   = 5'd1;
  localparam logic [4:0] reg_sp_c   = 5'd2;

  // prefix for the 3-bit compact registers, maps onto x8..x15
  localparam logic [1:0] prime_base_c = 2'b01;

  localparam logic [31:0] ebreak_c = 32'h0010_0073;

  //////////////////////////////
  // compressed formats, msb first

  // stack pointer add, scrambled 8-bit immediate
  typedef struct packed {
    logic [2:0] funct3;
    logic [7:0] imm;
    logic [2:0] rd_p;
    logic [1:0] op;
  } ciw_t;

  // compact load/store, also the register ALU form in quadrant 1
  typedef struct packed {
    logic [2:0] funct3;
    logic [2:0] imm_hi;
    logic [2:0] rs1_p;
    logic [1:0] imm_lo;
    logic [2:0] rd_rs2_p;
    logic [1:0] op;
  } cl_cs_t;

  // full rd with a split 6-bit immediate
  typedef struct packed {
    logic [2:0] funct3;
    logic       imm_hi;
    logic [4:0] rd;
    logic [4:0] imm_lo;
    logic [1:0] op;
  } ci_t;

  // stack store
  typedef struct packed {
    logic [2:0] funct3;
    logic [5:0] imm;
    logic [4:0] rs2;
    logic [1:0] op;
  } css_t;

  // branch, compact shift and andi
  typedef struct packed {
    logic [2:0] funct3;
    logic [2:0] hi;
    logic [2:0] rs1_p;
    logic [4:0] lo;
    logic [1:0] op;
  } cb_t;

  // jump, offset bits scattered over [12:2]
  typedef struct packed {
    logic [2:0]  funct3;
    logic [10:0] target;
    logic [1:0]  op;
  } cj_t;

  // one half word seen through each format
  typedef union packed {
    ciw_t   ciw;
    cl_cs_t cl_cs;
    ci_t    ci;
    css_t   css;
    cb_t    cb;
    cj_t    cj;
  } c_instr_u;

  //////////////////////////////
  // results

  // expander output, instr is don't care when illegal is set
  typedef struct packed {
    logic [ilen_p-1:0] instr;
    logic              illegal;
  } expand_res_t;

  typedef struct packed {
    logic [ilen_p-1:0] instr;
    logic              is_compressed;
    logic              illegal;
  } dec_out_t;

endpackage

// ==== expand/rvc_expand_q0.sv ====
//////////////////////////////
// quadrant 0 expander, purely combinational
// float loads and stores are only flagged illegal
//////////////////////////////

`timescale 1ns/1ps

module rvc_expand_q0 (
  input  rvc_pkg::c_instr_u    c_instr_i,
  output rvc_pkg::expand_res_t res_o
);

  import rvc_pkg::*;

  ciw_t       ciw;
  cl_cs_t     cl;
  logic [4:0] rd_full;
  logic [4:0] rs1_full;
  logic [9:2] spn_off;
  logic [6:2] word_off;

  assign ciw = c_instr_i.ciw;
  assign cl  = c_instr_i.cl_cs;

  assign rd_full  = {prime_base_c, cl.rd_rs2_p};
  assign rs1_full = {prime_base_c, cl.rs1_p};

  // addi4spn offset sits as [5:4|9:6|2|3]
  assign spn_off = {ciw.imm[5:2], ciw.imm[7:6], ciw.imm[0], ciw.imm[1]};

  // lw/sw offset sits as [5:3] at [12:10] and [2|6] at [6:5]
  assign word_off = {cl.imm_lo[0], cl.imm_hi, cl.imm_lo[1]};

  always_comb begin
    res_o.instr   = '0;
    res_o.illegal = 1'b0;
    case (ciw.funct3)
      3'b000: begin
        // c.addi4spn, addi rd', sp, nzuimm
        res_o.instr = {2'b00, spn_off, 2'b00, reg_sp_c, 3'b000,
                       2'b01, ciw.rd_p, opcode_opimm};
        res_o.illegal = (ciw.imm == 8'd0);
      end
      3'b010: begin
        // c.lw
        res_o.instr = {5'b00000, word_off, 2'b00, rs1_full, 3'b010,
                       rd_full, opcode_load};
      end
      3'b110: begin
        // c.sw, rd_rs2_p holds the source register here
        res_o.instr = {5'b00000, word_off[6:5], rd_full, rs1_full, 3'b010,
                       word_off[4:2], 2'b00, opcode_store};
      end
      default: begin
        // c.fld/c.flw/c.fsd/c.fsw and the reserved 100 slot
        res_o.illegal = 1'b1;
      end
    endcase
  end

endmodule

// ==== expand/rvc_expand_q1.sv ====
//////////////////////////////
// quadrant 1 expander, purely combinational
// RV32 only, so subw/addw and shamt[5] are illegal
// HINT encodings expand as ordinary instructions
//////////////////////////////

`timescale 1ns/1ps

module rvc_expand_q1 (
  input  rvc_pkg::c_instr_u    c_instr_i,
  output rvc_pkg::expand_res_t res_o
);

  import rvc_pkg::*;

  ci_t         ci;
  cb_t         cb;
  cl_cs_t      ca;
  logic [10:0] jt;
  logic [11:0] ci_imm;
  logic [11:0] sp16_imm;
  logic [11:1] j_off;
  logic [20:1] j_imm;
  logic [4:0]  jal_rd;
  logic [8:1]  b_off;
  logic [12:1] b_imm;
  logic [4:0]  rd_full;
  logic [4:0]  rs2_full;

  assign ci = c_instr_i.ci;
  assign cb = c_instr_i.cb;
  assign ca = c_instr_i.cl_cs;
  assign jt = c_instr_i.cj.target;

  assign ci_imm = {{7{ci.imm_hi}}, ci.imm_lo};

  // addi16sp keeps nzimm[9|4|6|8:7|5] in bits [12|6:2]
  assign sp16_imm = {{3{ci.imm_hi}}, ci.imm_lo[2:1], ci.imm_lo[3], ci.imm_lo[0],
                     ci.imm_lo[4], 4'b0000};

  // jump offset [11|4|9:8|10|6|7|3:1|5] unscrambled
  assign j_off  = {jt[10], jt[6], jt[8:7], jt[4], jt[5], jt[0], jt[9], jt[3:1]};
  assign j_imm  = {{9{j_off[11]}}, j_off};
  assign jal_rd = ci.funct3[2] ? reg_zero_c : reg_ra_c;

  // branch offset [8|4:3] in [12:10] and [7:6|2:1|5] in [6:2]
  assign b_off = {cb.hi[2], cb.lo[4:3], cb.lo[0], cb.hi[1:0], cb.lo[2:1]};
  assign b_imm = {{4{b_off[8]}}, b_off};

  assign rd_full  = {prime_base_c, cb.rs1_p};
  assign rs2_full = {prime_base_c, ca.rd_rs2_p};

  always_comb begin
    res_o.instr   = '0;
    res_o.illegal = 1'b0;
    case (ci.funct3)
      3'b000: begin
        // c.addi, c.nop when rd is zero
        res_o.instr = {ci_imm, ci.rd, 3'b000, ci.rd, opcode_opimm};
      end
      3'b001, 3'b101: begin
        // c.jal links ra, c.j links nothing
        res_o.instr = {j_imm[20], j_imm[10:1], j_imm[11], j_imm[19:12],
                       jal_rd, opcode_jal};
      end
      3'b010: begin
        // c.li
        res_o.instr = {ci_imm, reg_zero_c, 3'b000, ci.rd, opcode_opimm};
      end
      3'b011: begin
        res_o.illegal = ({ci.imm_hi, ci.imm_lo} == 6'd0);
        if (ci.rd == reg_sp_c) begin
          res_o.instr = {sp16_imm, reg_sp_c, 3'b000, reg_sp_c, opcode_opimm};
        end else begin
          // c.lui
          res_o.instr = {{15{ci.imm_hi}}, ci.imm_lo, ci.rd, opcode_lui};
        end
      end
      3'b100: begin
        case (cb.hi[1:0])
          2'b00, 2'b01: begin
            // c.srli / c.srai, bit 12 would be shamt[5]
            res_o.instr = {1'b0, cb.hi[0], 5'b00000, cb.lo, rd_full, 3'b101,
                           rd_full, opcode_opimm};
            res_o.illegal = cb.hi[2];
          end
          2'b10: begin
            // c.andi
            res_o.instr = {{7{cb.hi[2]}}, cb.lo, rd_full, 3'b111, rd_full,
                           opcode_opimm};
          end
          default: begin
            // register ALU ops, funct2 lives in imm_lo
            case (ca.imm_lo)
              2'b00: res_o.instr = {7'b0100000, rs2_full, rd_full, 3'b000, rd_full, opcode_op};
              2'b01: res_o.instr = {7'b0000000, rs2_full, rd_full, 3'b100, rd_full, opcode_op};
              2'b10: res_o.instr = {7'b0000000, rs2_full, rd_full, 3'b110, rd_full, opcode_op};
              default: res_o.instr = {7'b0000000, rs2_full, rd_full, 3'b111, rd_full,
                                      opcode_op};
            endcase
            // bit 12 set means subw/addw or a reserved code
            res_o.illegal = cb.hi[2];
          end
        endcase
      end
      default: begin
        // c.beqz / c.bnez, funct3[0] picks bne
        res_o.instr = {b_imm[12], b_imm[10:5], reg_zero_c, rd_full,
                       2'b00, ci.funct3[0], b_imm[4:1], b_imm[11], opcode_branch};
      end
    endcase

    // every legal expansion must land on a known major opcode
    assert (res_o.illegal || res_o.instr[6:0] inside {opcode_load, opcode_store,
        opcode_opimm, opcode_op, opcode_lui, opcode_jal, opcode_jalr, opcode_branch})
      else $error("q1 expansion produced an unknown opcode %h", res_o.instr[6:0]);
  end

endmodule

// ==== expand/rvc_expand_q2.sv ====
//////////////////////////////
// quadrant 2 expander, purely combinational
// float stack forms are only flagged illegal
//////////////////////////////

`timescale 1ns/1ps

module rvc_expand_q2 (
  input  rvc_pkg::c_instr_u    c_instr_i,
  output rvc_pkg::expand_res_t res_o
);

  import rvc_pkg::*;

  ci_t        ci;
  css_t       css;
  logic [7:2] lwsp_off;
  logic [7:2] swsp_off;

  assign ci  = c_instr_i.ci;
  assign css = c_instr_i.css;

  // lwsp keeps [5] at bit 12 and [4:2|7:6] at [6:2]
  assign lwsp_off = {ci.imm_lo[1:0], ci.imm_hi, ci.imm_lo[4:2]};
  // swsp keeps [5:2|7:6] at [12:7]
  assign swsp_off = {css.imm[1:0], css.imm[5:2]};

  always_comb begin
    res_o.instr   = '0;
    res_o.illegal = 1'b0;
    case (ci.funct3)
      3'b000: begin
        // c.slli
        res_o.instr = {7'b0000000, ci.imm_lo, ci.rd, 3'b001, ci.rd, opcode_opimm};
        res_o.illegal = ci.imm_hi;
      end
      3'b010: begin
        // c.lwsp
        res_o.instr = {4'b0000, lwsp_off, 2'b00, reg_sp_c, 3'b010, ci.rd, opcode_load};
        res_o.illegal = (ci.rd == reg_zero_c);
      end
      3'b100: begin
        // CR form, rs1/rd at [11:7] and rs2 at [6:2]
        if (css.rs2 == reg_zero_c) begin
          if (ci.imm_hi && (ci.rd == reg_zero_c)) begin
            res_o.instr = ebreak_c;
          end else begin
            // c.jr links nothing, c.jalr links ra
            res_o.instr = {12'd0, ci.rd, 3'b000, ci.imm_hi ? reg_ra_c : reg_zero_c,
                           opcode_jalr};
            res_o.illegal = !ci.imm_hi && (ci.rd == reg_zero_c);
          end
        end else if (ci.imm_hi) begin
          // c.add
          res_o.instr = {7'b0000000, css.rs2, ci.rd, 3'b000, ci.rd, opcode_op};
        end else begin
          // c.mv
          res_o.instr = {7'b0000000, css.rs2, reg_zero_c, 3'b000, ci.rd, opcode_op};
        end
      end
      3'b110: begin
        // c.swsp
        res_o.instr = {4'b0000, swsp_off[7:5], css.rs2, reg_sp_c, 3'b010,
                       swsp_off[4:2], 2'b00, opcode_store};
      end
      default: begin
        // fldsp, flwsp, fsdsp, fswsp
        res_o.illegal = 1'b1;
      end
    endcase
  end

endmodule

// ==== rtl/rvc_decode_stage.sv ====
//////////////////////////////
// quadrant select and one-deep output register
// expander results must match in_data_i in the same cycle
// a full word passes unchanged and is never illegal
//////////////////////////////

`timescale 1ns/1ps

module rvc_decode_stage (
  input  logic                       clk,
  input  logic                       reset_i,
  input  logic                       in_valid_i,
  input  logic [rvc_pkg::ilen_p-1:0] in_data_i,
  output logic                       in_ready_o,
  input  rvc_pkg::expand_res_t       q0_res_i,
  input  rvc_pkg::expand_res_t       q1_res_i,
  input  rvc_pkg::expand_res_t       q2_res_i,
  output logic                       out_valid_o,
  output rvc_pkg::dec_out_t          out_data_o,
  input  logic                       out_ready_i
);

  import rvc_pkg::*;

  expand_res_t sel_res;
  dec_out_t    data_q;
  logic        valid_q;
  logic        accept;

  always_comb begin
    case (in_data_i[1:0])
      2'b00:   sel_res = q0_res_i;
      2'b01:   sel_res = q1_res_i;
      2'b10:   sel_res = q2_res_i;
      default: sel_res = {in_data_i, 1'b0};
    endcase
  end

  //////////////////////////////
  // output register

  // take a new word when empty or when the current one leaves
  assign in_ready_o = !valid_q || out_ready_i;
  assign accept     = in_valid_i && in_ready_o;

  always_ff @(posedge clk) begin
    if (reset_i) begin
      valid_q <= 1'b0;
    end else if (in_ready_o) begin
      valid_q <= in_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      data_q.instr         <= sel_res.instr;
      data_q.is_compressed <= (in_data_i[1:0] != 2'b11);
      data_q.illegal       <= sel_res.illegal;
    end
  end

  assign out_valid_o = valid_q;
  assign out_data_o  = data_q;

  // a stalled result must not change or vanish
  assert property (@(posedge clk) disable iff (reset_i)
      out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_data_o))
    else $error("output changed while stalled");

  assert property (@(posedge clk) reset_i |=> !out_valid_o)
    else $error("output valid right after reset");

endmodule

// ==== rtl/rvc_decoder_top.sv ====
//////////////////////////////
// RV32C expansion stage, one word per cycle at full rate
// output appears one cycle after acceptance
//////////////////////////////

`timescale 1ns/1ps

module rvc_decoder_top (
  input  logic                       clk,
  input  logic                       reset_i,
  input  logic                       in_valid_i,
  input  logic [rvc_pkg::ilen_p-1:0] in_data_i,
  output logic                       in_ready_o,
  output logic                       out_valid_o,
  output rvc_pkg::dec_out_t          out_data_o,
  input  logic                       out_ready_i
);

  import rvc_pkg::*;

  c_instr_u    c_instr;
  expand_res_t q0_res;
  expand_res_t q1_res;
  expand_res_t q2_res;

  // the low half word is the candidate compressed instruction
  assign c_instr = in_data_i[clen_p-1:0];

  rvc_expand_q0 expand_q0_i (
    .c_instr_i (c_instr),
    .res_o     (q0_res)
  );

  rvc_expand_q1 expand_q1_i (
    .c_instr_i (c_instr),
    .res_o     (q1_res)
  );

  rvc_expand_q2 expand_q2_i (
    .c_instr_i (c_instr),
    .res_o     (q2_res)
  );

  rvc_decode_stage decode_stage_i (
    .clk         (clk),
    .reset_i     (reset_i),
    .in_valid_i  (in_valid_i),
    .in_data_i   (in_data_i),
    .in_ready_o  (in_ready_o),
    .q0_res_i    (q0_res),
    .q1_res_i    (q1_res),
    .q2_res_i    (q2_res),
    .out_valid_o (out_valid_o),
    .out_data_o  (out_data_o),
    .out_ready_i (out_ready_i)
  );

endmodule

// ==== tests/rvc_decoder_tb.sv ====
//////////////////////////////
// testbench for the RV32C expansion stage
// vectors come from tests/rvc_stimulus.txt, run from the project root
// out_ready_i toggles randomly, stops at the first failing check
//////////////////////////////

`timescale 1ns/1ps

module rvc_decoder_tb;

  import rvc_pkg::*;

  localparam int timeout_cycles_c = 100;

  logic        clk;
  logic        reset_i;
  logic        in_valid_i;
  logic [31:0] in_data_i;
  logic        in_ready_o;
  logic        out_valid_o;
  dec_out_t    out_data_o;
  logic        out_ready_i;

  logic [31:0] vec_in [$];
  dec_out_t    vec_exp [$];
  dec_out_t    exp_q [$];
  logic [31:0] rng_state;

  // state carried from one sampled cycle to the next
  logic        took_prev;
  dec_out_t    took_exp;
  logic        held_valid;
  dec_out_t    held_data;

  rvc_decoder_top dut_i (
    .clk         (clk),
    .reset_i     (reset_i),
    .in_valid_i  (in_valid_i),
    .in_data_i   (in_data_i),
    .in_ready_o  (in_ready_o),
    .out_valid_o (out_valid_o),
    .out_data_o  (out_data_o),
    .out_ready_i (out_ready_i)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  //////////////////////////////
  // helpers

  task automatic stop_run();
    $display("Simulation failed");
    $fatal(1, "stopped at the first failing check");
  endtask

  task automatic report_value_error(input string what, input dec_out_t got,
                                    input dec_out_t exp);
    $display("[ERROR] t=%0t: %s, got %h c=%0b ill=%0b, expected %h c=%0b ill=%0b",
             $time, what, got.instr, got.is_compressed, got.illegal,
             exp.instr, exp.is_compressed, exp.illegal);
    stop_run();
  endtask

  // xorshift32
  function automatic logic [31:0] next_random(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // downstream ready about three cycles in four
  function automatic logic random_ready();
    rng_state = next_random(rng_state);
    return rng_state[1:0] != 2'b00;
  endfunction

  // the instruction word only matters for legal results
  function automatic logic matches_expected(input dec_out_t got, input dec_out_t exp);
    logic same_flags;
    same_flags = (got.is_compressed === exp.is_compressed) &&
                 (got.illegal === exp.illegal);
    if (exp.illegal) begin
      return same_flags;
    end
    return same_flags && (got.instr === exp.instr);
  endfunction

  task automatic load_vectors();
    int          fd;
    int          n;
    string       line;
    logic [31:0] word_in;
    logic [31:0] word_exp;
    logic        c_bit;
    logic        ill_bit;
    dec_out_t    e;
    fd = $fopen("tests/rvc_stimulus.txt", "r");
    if (fd == 0) begin
      $display("could not open the stimulus file tests/rvc_stimulus.txt");
      stop_run();
    end else begin
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        // skip blank lines and the column notes
        if (n > 0 && line.len() > 1 && line.getc(0) != 8'h2f) begin
          n = $sscanf(line, "%h %h %b %b", word_in, word_exp, c_bit, ill_bit);
          if (n == 4) begin
            e.instr         = word_exp;
            e.is_compressed = c_bit;
            e.illegal       = ill_bit;
            vec_in.push_back(word_in);
            vec_exp.push_back(e);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // called at the falling edge, when every signal is settled for the next rising edge
  task automatic check_output_cycle(input dec_out_t cur_exp);
    dec_out_t front;
    logic     ready_exp;
    // a stalled output blocks the input, otherwise one word per cycle
    if (out_valid_o && !out_ready_i) begin
      ready_exp = 1'b0;
    end else begin
      ready_exp = 1'b1;
    end
    assert (in_ready_o === ready_exp)
      else begin
        $display("[ERROR] t=%0t: in_ready_o=%b, expected %b with out_valid_o=%b out_ready_i=%b",
                 $time, in_ready_o, ready_exp, out_valid_o, out_ready_i);
        stop_run();
      end
    if (took_prev) begin
      assert (out_valid_o && matches_expected(out_data_o, took_exp))
        else report_value_error("word not registered one cycle after accept",
                                out_data_o, took_exp);
    end
    if (held_valid) begin
      assert (out_valid_o && out_data_o === held_data)
        else report_value_error("output changed while stalled", out_data_o, held_data);
    end
    if (out_valid_o && out_ready_i) begin
      assert (exp_q.size() != 0)
        else report_value_error("output transfer with nothing outstanding",
                                out_data_o, '0);
      if (exp_q.size() != 0) begin
        front = exp_q.pop_front();
        assert (matches_expected(out_data_o, front))
          else report_value_error("wrong result", out_data_o, front);
      end
    end
    held_valid = out_valid_o && !out_ready_i;
    held_data  = out_data_o;
    took_prev  = in_valid_i && in_ready_o;
    took_exp   = cur_exp;
    if (took_prev) begin
      exp_q.push_back(cur_exp);
    end
  endtask

  //////////////////////////////
  // traffic

  task automatic run_traffic();
    int       idx;
    int       waited;
    dec_out_t next_exp;
    idx    = 0;
    waited = 0;
    while (idx < vec_in.size()) begin
      @(posedge clk);
      #1;
      in_valid_i  = 1'b1;
      in_data_i   = vec_in[idx];
      out_ready_i = random_ready();
      next_exp    = vec_exp[idx];
      @(negedge clk);
      check_output_cycle(next_exp);
      if (took_prev) begin
        idx++;
        waited = 0;
      end else begin
        waited++;
        if (waited >= timeout_cycles_c) begin
          $display("timeout: the input handshake never completed in %0d cycles",
                   timeout_cycles_c);
          stop_run();
        end
      end
    end
  endtask

  task automatic drain_output();
    int waited;
    waited = 0;
    while (exp_q.size() != 0) begin
      @(posedge clk);
      #1;
      in_valid_i  = 1'b0;
      out_ready_i = random_ready();
      @(negedge clk);
      check_output_cycle('0);
      waited++;
      if (waited >= timeout_cycles_c) begin
        $display("timeout: the output handshake never completed in %0d cycles",
                 timeout_cycles_c);
        stop_run();
      end
    end
  endtask

  initial begin
    reset_i     = 1'b1;
    in_valid_i  = 1'b0;
    in_data_i   = '0;
    out_ready_i = 1'b0;
    rng_state   = 32'd67;
    took_prev   = 1'b0;
    took_exp    = '0;
    held_valid  = 1'b0;
    held_data   = '0;
    load_vectors();
    if (vec_in.size() == 0) begin
      $display("the stimulus file holds no vectors");
      stop_run();
    end
    repeat (16) @(posedge clk);
    #1;
    reset_i = 1'b0;
    @(negedge clk);
    assert (!out_valid_o && in_ready_o)
      else begin
        $display("[ERROR] t=%0t: not idle after reset, out_valid_o=%b in_ready_o=%b",
                 $time, out_valid_o, in_ready_o);
        stop_run();
      end
    run_traffic();
    drain_output();
    $display("Simulation passed");
    $finish;
  end

endmodule

// ==== tests/rvc_stimulus.txt ====
// input_word expected_word is_compressed illegal (hex, hex, bit, bit)
// expected_word is not compared when illegal is 1
00500093 00500093 0 0
002081b3 002081b3 0 0
00000800 01010413 1 0
00001fe4 3fc10493 1 0
00000000 00000000 1 1
00005c7c 07c42783 1 0
0000c124 04952023 1 0
00002000 00000000 1 1
0000e000 00000000 1 1
00000001 00000013 1 0
000012fd fff28293 1 0
0000457d 01f00513 1 0
000077fd fffff7b7 1 0
0000717d ff010113 1 0
00006101 00000000 1 1
00002021 008000ef 1 0
0000bffd fffff06f 1 0
00002105 420000ef 1 0
000084fd 41f4d493 1 0
00009971 ffc57513 1 0
00008c05 40940433 1 0
00008db1 00c5c5b3 1 0
00008f5d 00f76733 1 0
00008ee1 0086f6b3 1 0
00009c01 00000000 1 1
00009c21 00000000 1 1
0000c801 00040863 1 0
0000fcfd fe049fe3 1 0
0000028e 00329293 1 0
000040b2 00c12083 1 0
0000557e 0fc12503 1 0
00004002 00000000 1 1
0000c5a2 0c812423 1 0
ffff8082 00008067 1 0
00009282 000280e7 1 0
00008002 00000000 1 1
0000852e 00b00533 1 0
0000952e 00b50533 1 0
00009002 00100073 1 0
0000e002 00000000 1 1

// ==== build.f ====
common/rvc_pkg.sv
expand/rvc_expand_q0.sv
expand/rvc_expand_q1.sv
expand/rvc_expand_q2.sv
rtl/rvc_decode_stage.sv
rtl/rvc_decoder_top.sv
tests/rvc_decoder_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= rvc_decoder_tb
FILELIST  ?= build.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: sim clean

# the simulation reads tests/rvc_stimulus.txt, so it runs from this directory
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	grep -q "Simulation passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
